/* Makefile */
TOP := pktgen_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f -o simv
	./obj_dir/simv | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf obj_dir

/* all.f */
src/pktgen_pkg.sv
src/csr_regs.sv
src/prbs23_lane.sv
src/payload_source.sv
src/frame_sequencer.sv
src/pktgen_top.sv
tests/pktgen_props.sv
tests/pktgen_checker.sv
tests/pktgen_tb.sv

/* src/csr_regs.sv */
// --------------------------------------
// Generator register file
// --------------------------------------

module csr_regs import pktgen_pkg::*; (
   input  logic              clk,
   input  logic              reset,
   input  csr_req_t          csr,
   output logic [CSR_DW-1:0] readdata,
   output logic              waitrequest,
   input  logic [31:0]       tx_pkt_count,
   output gen_cfg_t          cfg,
   output logic              start
);

   logic        acc_ack;         // Second cycle of an access
   logic        wr_en;
   logic        rd_en;
   logic [31:0] num_packets;
   logic        random_payload;
   logic        stop;
   logic [31:0] mac_sa0;
   logic [15:0] mac_sa1;
   logic [31:0] mac_da0;
   logic [15:0] mac_da1;
   logic [31:0] seed0;
   logic [31:0] seed1;
   logic [4:0]  seed2;
   logic [13:0] pkt_len;

   // --------------------------------------
   // Bus handshake
   // --------------------------------------
   // Wait in the first cycle of each access, release in the second
   assign waitrequest = (csr.read | csr.write) & ~acc_ack;
   assign wr_en       = csr.write & waitrequest;  // Writes land once per access
   assign rd_en       = csr.read & waitrequest;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         acc_ack <= 1'b0;
      end else begin
         acc_ack <= waitrequest;
      end
   end

   // --------------------------------------
   // Configuration registers
   // --------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         num_packets    <= '0;
         random_payload <= 1'b0;
         stop           <= 1'b0;
         mac_sa0        <= '0;
         mac_sa1        <= '0;
         mac_da0        <= '0;
         mac_da1        <= '0;
         seed0          <= SEED_RESET0;
         seed1          <= SEED_RESET1;
         seed2          <= SEED_RESET2;
         pkt_len        <= '0;
         start          <= 1'b0;
      end else begin
         start <= wr_en & (csr.address == ADDR_START) & csr.writedata[0];  // Single pulse
         if (wr_en) begin
            case (csr.address)
               ADDR_NUMPKTS:       num_packets    <= csr.writedata;
               ADDR_RANDOMPAYLOAD: random_payload <= csr.writedata[0];
               ADDR_STOP:          stop           <= csr.writedata[0];
               ADDR_MACSA0:        mac_sa0        <= csr.writedata;
               ADDR_MACSA1:        mac_sa1        <= csr.writedata[15:0];
               ADDR_MACDA0:        mac_da0        <= csr.writedata;
               ADDR_MACDA1:        mac_da1        <= csr.writedata[15:0];
               ADDR_RNDSEED0:      seed0          <= csr.writedata;
               ADDR_RNDSEED1:      seed1          <= csr.writedata;
               ADDR_RNDSEED2:      seed2          <= csr.writedata[4:0];
               ADDR_PKTLENGTH:     pkt_len        <= (csr.writedata > MAX_PAYLOAD) ?
                                                     14'(MAX_PAYLOAD) : csr.writedata[13:0];
               default: ;                                     // START and read-only space
            endcase
         end
      end
   end

   // Registered read mux, valid when waitrequest drops
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         readdata <= '0;
      end else if (rd_en) begin
         case (csr.address)
            ADDR_NUMPKTS:       readdata <= num_packets;
            ADDR_RANDOMPAYLOAD: readdata <= {31'd0, random_payload};
            ADDR_STOP:          readdata <= {31'd0, stop};
            ADDR_MACSA0:        readdata <= mac_sa0;
            ADDR_MACSA1:        readdata <= {16'd0, mac_sa1};
            ADDR_MACDA0:        readdata <= mac_da0;
            ADDR_MACDA1:        readdata <= {16'd0, mac_da1};
            ADDR_TXPKTCNT:      readdata <= tx_pkt_count;
            ADDR_RNDSEED0:      readdata <= seed0;
            ADDR_RNDSEED1:      readdata <= seed1;
            ADDR_RNDSEED2:      readdata <= {27'd0, seed2};
            ADDR_PKTLENGTH:     readdata <= {18'd0, pkt_len};
            default:            readdata <= '0;              // START reads 0 too
         endcase
      end
   end

   assign cfg = '{num_packets:    num_packets,
                  random_payload: random_payload,
                  stop:           stop,
                  mac_da:         {mac_da1, mac_da0},
                  mac_sa:         {mac_sa1, mac_sa0},
                  seed:           {seed2, seed1, seed0},
                  payload_len:    pkt_len};

endmodule

/* src/frame_sequencer.sv */
// --------------------------------------
// Frame sequencer
// --------------------------------------

module frame_sequencer import pktgen_pkg::*; (
   input  logic              clk,
   input  logic              reset,
   input  gen_cfg_t          cfg,
   input  logic              start,
   input  logic              tx_ready,
   input  logic [BEAT_W-1:0] pay_word,
   output st_beat_t          tx,
   output logic              load,
   output logic              frame_start,
   output logic              advance,
   output logic              random_payload,
   output logic [SEED_W-1:0] seed,
   output logic [31:0]       tx_pkt_count
);

   logic [2:0]  state_q;     // Kind of beat held in the output register
   logic [2:0]  state_d;
   logic        beat_acc;    // Output beat taken this cycle
   logic        step;        // Output register loads a new beat
   logic        run_done;
   logic        last_beat;   // Next payload beat closes the frame
   logic [13:0] len_q;       // Payload length of the current frame
   logic [13:0] rem_q;       // Payload bytes not yet loaded
   logic [15:0] seq_q;
   logic        valid_q;
   logic        sop_q;
   logic        eop_q;
   logic [2:0]  empty_q;
   eth_word_u   data_q;
   logic        valid_d;
   logic        sop_d;
   logic        eop_d;
   logic [2:0]  empty_d;
   eth_word_u   data_d;

   assign beat_acc  = valid_q & tx_ready;
   assign run_done  = cfg.stop | (tx_pkt_count >= cfg.num_packets);
   assign last_beat = rem_q <= 14'(BEAT_BYTES);

   // --------------------------------------
   // State machine
   // --------------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: if (start && cfg.num_packets != '0) state_d = ST_HDR0;
         ST_HDR0: if (tx_ready) state_d = ST_HDR1;
         ST_HDR1,
         ST_PAY:  if (tx_ready) state_d = eop_q ? ST_GAP : ST_PAY;
         ST_GAP:  state_d = run_done ? ST_IDLE : ST_HDR0;     // Frame boundary check
         default: state_d = ST_IDLE;
      endcase
   end

   // Accepted beat or a move out of IDLE/GAP
   assign step = beat_acc | (state_d != state_q);

   // --------------------------------------
   // Beat formation
   // --------------------------------------
   always_comb begin
      valid_d     = 1'b0;
      sop_d       = 1'b0;
      eop_d       = 1'b0;
      empty_d     = '0;
      data_d.raw  = pay_word;
      case (state_d)
         ST_HDR0: begin
            valid_d           = 1'b1;
            sop_d             = 1'b1;
            data_d.hdr0.da    = cfg.mac_da;
            data_d.hdr0.sa_hi = cfg.mac_sa[47:32];
         end
         ST_HDR1: begin
            valid_d           = 1'b1;
            eop_d             = (len_q == '0);                 // Header-only frame
            data_d.hdr1.sa_lo = cfg.mac_sa[31:0];
            data_d.hdr1.len   = {2'b00, len_q};
            data_d.hdr1.seq   = seq_q;
         end
         ST_PAY: begin
            valid_d = 1'b1;
            eop_d   = last_beat;
            if (last_beat) begin
               empty_d = 3'(4'(BEAT_BYTES) - rem_q[3:0]);       // rem is 1..8 here
            end
         end
         default: ;                                             // IDLE and GAP send nothing
      endcase
   end

   // --------------------------------------
   // Registers
   // --------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state_q      <= ST_IDLE;
         valid_q      <= 1'b0;
         sop_q        <= 1'b0;
         eop_q        <= 1'b0;
         empty_q      <= '0;
         len_q        <= '0;
         rem_q        <= '0;
         seq_q        <= '0;
         tx_pkt_count <= '0;
      end else begin
         state_q <= state_d;
         if (step) begin                                        // Held while ready is low
            valid_q <= valid_d;
            sop_q   <= sop_d;
            eop_q   <= eop_d;
            empty_q <= empty_d;
         end
         if (step && state_d == ST_HDR0) begin
            len_q <= cfg.payload_len;                           // Frozen for the frame
         end
         if (step && state_d == ST_HDR1) begin
            rem_q <= len_q;
         end else if (step && state_d == ST_PAY) begin
            rem_q <= rem_q - 14'(BEAT_BYTES);
         end
         if (start) begin
            seq_q <= '0;
         end else if (step && state_d == ST_HDR1) begin
            seq_q <= seq_q + 16'd1;                             // Next frame's number
         end
         if (start) begin
            tx_pkt_count <= '0;
         end else if (beat_acc && sop_q) begin
            tx_pkt_count <= tx_pkt_count + 32'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (step) begin
         data_q <= data_d;
      end
   end

   // Payload source control, advance runs one beat ahead of its payload beat
   assign load        = (state_q == ST_IDLE);
   assign frame_start = step & (state_d == ST_HDR0);
   assign advance     = step & (((state_d == ST_HDR1) & (len_q != '0)) |
                                ((state_d == ST_PAY) & ~last_beat));

   assign random_payload = cfg.random_payload;
   assign seed           = cfg.seed;

   assign tx = '{valid: valid_q, sop: sop_q, eop: eop_q, empty: empty_q, data: data_q};

endmodule

/* src/payload_source.sv */
// --------------------------------------
// Payload word source
// --------------------------------------

module payload_source import pktgen_pkg::*; (
   input  logic              clk,
   input  logic              reset,
   input  logic              random_payload,
   input  logic [SEED_W-1:0] seed,
   input  logic              load,         // Sequencer idle
   input  logic              frame_start,  // hdr0 loaded
   input  logic              advance,      // Step to the next payload word
   output logic [BEAT_W-1:0] pay_word
);

   logic [SEED_W-1:0] lanes;     // lane2 | lane1 | lane0
   logic [7:0]        inc_byte;  // First byte of the current word
   logic [BEAT_W-1:0] inc_word;

   // Three lanes, each on its own slice of the seed
   for (genvar g = 0; g < PRBS_LANES; g++) begin : g_lane
      prbs23_lane u_lane (
         .clk    (clk),
         .reset  (reset),
         .load   (load),
         .enable (advance),
         .seed   (seed[g*PRBS_W +: PRBS_W]),
         .state  (lanes[g*PRBS_W +: PRBS_W])
      );
   end

   // --------------------------------------
   // Incrementing pattern
   // --------------------------------------
   // Starts one word back, the advance ahead of payload beat 1 brings it to 0
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         inc_byte <= '0;
      end else if (frame_start) begin
         inc_byte <= 8'(-BEAT_BYTES);
      end else if (advance) begin
         inc_byte <= inc_byte + 8'(BEAT_BYTES);                 // Wraps mod 256
      end
   end

   always_comb begin
      for (int i = 0; i < BEAT_BYTES; i++) begin
         inc_word[BEAT_W-1-8*i -: 8] = inc_byte + 8'(i);        // Byte 0 at the top
      end
   end

   assign pay_word = random_payload ? lanes[BEAT_W-1:0] : inc_word;

endmodule

/* src/pktgen_pkg.sv */
// --------------------------------------
// Frame generator shared definitions
// --------------------------------------

package pktgen_pkg;

   // --------------------------------------
   // Register map
   // --------------------------------------
   localparam logic [7:0] ADDR_NUMPKTS       = 8'h00;
   localparam logic [7:0] ADDR_RANDOMPAYLOAD = 8'h02;  // 0x01 left unused
   localparam logic [7:0] ADDR_START         = 8'h03;
   localparam logic [7:0] ADDR_STOP          = 8'h04;
   localparam logic [7:0] ADDR_MACSA0        = 8'h05;  // SA[31:0]
   localparam logic [7:0] ADDR_MACSA1        = 8'h06;  // SA[47:32]
   localparam logic [7:0] ADDR_MACDA0        = 8'h07;  // DA[31:0]
   localparam logic [7:0] ADDR_MACDA1        = 8'h08;  // DA[47:32]
   localparam logic [7:0] ADDR_TXPKTCNT      = 8'h09;  // Read only
   localparam logic [7:0] ADDR_RNDSEED0      = 8'h0A;
   localparam logic [7:0] ADDR_RNDSEED1      = 8'h0B;
   localparam logic [7:0] ADDR_RNDSEED2      = 8'h0C;  // Bits 4..0 only
   localparam logic [7:0] ADDR_PKTLENGTH     = 8'h0D;

   localparam int CSR_DW              = 32;
   localparam int BEAT_BYTES          = 8;
   localparam int BEAT_W              = 8 * BEAT_BYTES;
   localparam int unsigned MAX_PAYLOAD = 9000;         // Payload byte limit

   // PRBS lanes, x^23 + x^18 + 1
   localparam int PRBS_W     = 23;
   localparam int PRBS_TAP   = 18;
   localparam int PRBS_LANES = 3;
   localparam int SEED_W     = PRBS_LANES * PRBS_W;  // 69 seed bits

   // Nonzero so PRBS mode runs without a user seed
   localparam logic [CSR_DW-1:0] SEED_RESET0 = 32'h5EED_0000;
   localparam logic [CSR_DW-1:0] SEED_RESET1 = 32'h5EED_0001;
   localparam logic [4:0]        SEED_RESET2 = 5'h15;

   // Sequencer states
   localparam logic [2:0] ST_IDLE = 3'd0;
   localparam logic [2:0] ST_HDR0 = 3'd1;  // DA and SA high
   localparam logic [2:0] ST_HDR1 = 3'd2;  // SA low, length, sequence
   localparam logic [2:0] ST_PAY  = 3'd3;
   localparam logic [2:0] ST_GAP  = 3'd4;  // One idle cycle between frames

   // --------------------------------------
   // Types
   // --------------------------------------
   typedef struct packed {
      logic [7:0]        address;
      logic              read;
      logic              write;
      logic [CSR_DW-1:0] writedata;
   } csr_req_t;

   typedef struct packed {
      logic [31:0]       num_packets;
      logic              random_payload;
      logic              stop;
      logic [47:0]       mac_da;
      logic [47:0]       mac_sa;
      logic [SEED_W-1:0] seed;
      logic [13:0]       payload_len;
   } gen_cfg_t;

   // One stream beat seen as raw payload or as either header word
   typedef union packed {
      logic [BEAT_W-1:0] raw;
      struct packed {
         logic [47:0] da;
         logic [15:0] sa_hi;
      } hdr0;
      struct packed {
         logic [31:0] sa_lo;
         logic [15:0] len;
         logic [15:0] seq;
      } hdr1;
   } eth_word_u;

   typedef struct packed {
      logic      valid;
      logic      sop;
      logic      eop;
      logic [2:0] empty;   // Unused bytes in the eop beat
      eth_word_u data;     // Byte 0 in bits 63..56
   } st_beat_t;

endpackage

/* src/pktgen_top.sv */
// --------------------------------------
// Ethernet frame generator
// --------------------------------------

module pktgen_top import pktgen_pkg::*; (
   input  logic              clk,
   input  logic              reset,
   input  csr_req_t          csr,
   output logic [CSR_DW-1:0] readdata,
   output logic              waitrequest,
   input  logic              tx_ready,
   output st_beat_t          tx
);

   gen_cfg_t          cfg;
   logic              start;           // One cycle after the START write
   logic [31:0]       tx_pkt_count;
   logic              load;
   logic              frame_start;
   logic              advance;
   logic              random_payload;
   logic [SEED_W-1:0] seed;
   logic [BEAT_W-1:0] pay_word;

   csr_regs u_csr_regs (
      .clk          (clk),
      .reset        (reset),
      .csr          (csr),
      .readdata     (readdata),
      .waitrequest  (waitrequest),
      .tx_pkt_count (tx_pkt_count),
      .cfg          (cfg),
      .start        (start)
   );

   frame_sequencer u_frame_sequencer (
      .clk            (clk),
      .reset          (reset),
      .cfg            (cfg),
      .start          (start),
      .tx_ready       (tx_ready),
      .pay_word       (pay_word),
      .tx             (tx),
      .load           (load),
      .frame_start    (frame_start),
      .advance        (advance),
      .random_payload (random_payload),
      .seed           (seed),
      .tx_pkt_count   (tx_pkt_count)
   );

   payload_source u_payload_source (
      .clk            (clk),
      .reset          (reset),
      .random_payload (random_payload),
      .seed           (seed),
      .load           (load),
      .frame_start    (frame_start),
      .advance        (advance),
      .pay_word       (pay_word)
   );

endmodule

/* src/prbs23_lane.sv */
// --------------------------------------
// PRBS23 lane
// --------------------------------------

module prbs23_lane import pktgen_pkg::*; (
   input  logic              clk,
   input  logic              reset,
   input  logic              load,     // Take the seed
   input  logic              enable,   // Jump one full word
   input  logic [PRBS_W-1:0] seed,
   output logic [PRBS_W-1:0] state
);

   logic [PRBS_W-1:0] jump;  // State after PRBS_W single shifts

   // Right shift, feedback enters at the top
   always_comb begin
      jump = state;
      for (int i = 0; i < PRBS_W; i++) begin
         jump = {jump[PRBS_TAP] ^ jump[0], jump[PRBS_W-1:1]};
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= '0;
      end else if (load) begin
         state <= seed;
      end else if (enable) begin
         state <= jump;
      end
   end

endmodule

/* tests/pktgen_checker.sv */
// --------------------------------------
// Stream and register checker
// --------------------------------------

module pktgen_checker import pktgen_pkg::*; (
   input  logic              clk,
   input  logic              reset,
   input  csr_req_t          csr,
   input  logic [CSR_DW-1:0] readdata,
   input  logic              waitrequest,
   input  logic              tx_ready,
   input  st_beat_t          tx,
   input  logic [8*24-1:0]   test_name,
   input  logic              test_done,
   input  logic              all_done,
   output int                errors
);
   timeunit 1ns;
   timeprecision 100ps;

   // Register model
   logic [31:0]       m_num;
   logic [31:0]       m_sa0;
   logic [31:0]       m_da0;
   logic [31:0]       m_seed0;
   logic [31:0]       m_seed1;
   logic [31:0]       m_count;      // Frames seen since start
   logic [31:0]       exp_rd;       // Expected read data
   logic [15:0]       m_sa1;
   logic [15:0]       m_da1;
   logic [15:0]       m_seq;
   logic [4:0]        m_seed2;
   logic [13:0]       m_len;
   logic              m_rnd;
   logic              m_stop;
   logic              prev_valid;
   logic [SEED_W-1:0] lanes;
   // Frame tracking and tallies
   int                beat_idx;
   int                f_len;
   int                stop_age;     // Cycles since stop was set
   int                t_errs;
   int                t_beats;
   int                t_frames;
   int                n_tests;
   int                n_failed;
   st_beat_t          e;

   // --------------------------------------
   // Reference model
   // --------------------------------------
   // One word jump of all three lanes as 23 right shifts each
   function automatic logic [SEED_W-1:0] prbs_step(input logic [SEED_W-1:0] s);
      logic [22:0]       lane;
      logic [SEED_W-1:0] r;
      for (int l = 0; l < 3; l++) begin
         lane = s[l*23 +: 23];
         for (int k = 0; k < 23; k++) begin
            lane = {lane[18] ^ lane[0], lane[22:1]};
         end
         r[l*23 +: 23] = lane;
      end
      return r;
   endfunction

   function automatic st_beat_t ref_beat(input int idx, input int len,
         input logic [15:0] seq, input logic [47:0] da, input logic [47:0] sa,
         input logic rnd, input logic [SEED_W-1:0] ln);
      st_beat_t b;
      int       last;
      b = '0;
      b.valid = 1'b1;
      last = (len == 0) ? 1 : 1 + (len + 7) / 8;
      if (idx == 0) begin
         b.sop = 1'b1;
         b.data.raw = {da, sa[47:32]};
      end else if (idx == 1) begin
         b.data.raw = {sa[31:0], 16'(len), seq};
      end else if (rnd) begin
         b.data.raw = ln[63:0];                     // lane2 | lane1 | lane0, low 64 bits
      end else begin
         for (int i = 0; i < 8; i++) begin
            b.data.raw[63-8*i -: 8] = 8'(((idx - 2) * 8 + i) % 256);
         end
      end
      if (idx == last) begin
         b.eop = 1'b1;
         b.empty = (len == 0) ? 3'd0 : 3'((8 - len % 8) % 8);
      end
      return b;
   endfunction

   function automatic logic [31:0] read_model(input logic [7:0] a);
      case (a)
         ADDR_NUMPKTS:       return m_num;
         ADDR_RANDOMPAYLOAD: return {31'd0, m_rnd};
         ADDR_STOP:          return {31'd0, m_stop};
         ADDR_MACSA0:        return m_sa0;
         ADDR_MACSA1:        return {16'd0, m_sa1};
         ADDR_MACDA0:        return m_da0;
         ADDR_MACDA1:        return {16'd0, m_da1};
         ADDR_TXPKTCNT:      return m_count;
         ADDR_RNDSEED0:      return m_seed0;
         ADDR_RNDSEED1:      return m_seed1;
         ADDR_RNDSEED2:      return {27'd0, m_seed2};
         ADDR_PKTLENGTH:     return {18'd0, m_len};
         default:            return 32'd0;
      endcase
   endfunction

   task automatic count_error();
      errors++;
      t_errs++;
   endtask

   // --------------------------------------
   // Compare process
   // --------------------------------------
   always @(posedge clk or posedge reset) begin
      if (reset) begin
         {m_num, m_sa0, m_da0, m_count, m_sa1, m_da1, m_seq, m_len} = '0;
         {m_rnd, m_stop, prev_valid} = '0;
         m_seed0 = SEED_RESET0;
         m_seed1 = SEED_RESET1;
         m_seed2 = SEED_RESET2;
         lanes = '0;
         beat_idx = 0;
         stop_age = 0;
      end else begin
         // Read data is taken before this edge's frame count update
         if (csr.read && waitrequest) exp_rd = read_model(csr.address);

         // A frame loaded once stop has settled is an error
         if (tx.valid && tx.sop && !prev_valid && stop_age >= 2) begin
            $display("Error in %0s: a frame started after stop was set", test_name);
            count_error();
         end
         if (tx.valid && tx_ready) begin
            if (beat_idx == 0) f_len = int'(m_len);
            if (m_rnd && beat_idx >= 2) lanes = prbs_step(lanes);
            e = ref_beat(beat_idx, f_len, m_seq, {m_da1, m_da0}, {m_sa1, m_sa0},
                         m_rnd, lanes);
            if (tx !== e) begin
               $display("** Error %0s frame %0d beat %0d: expected %h, actual %h",
                        test_name, m_seq, beat_idx, e, tx);
               count_error();
            end
            t_beats++;
            if (tx.sop) begin
               m_count++;
               t_frames++;
            end
            if (e.eop) begin
               beat_idx = 0;
               m_seq++;
            end else begin
               beat_idx++;
            end
         end
         prev_valid = tx.valid;

         // Register bus snoop
         if (csr.read && !waitrequest && readdata !== exp_rd) begin
            $display("** Error %0s read 0x%h: expected %h, actual %h",
                     test_name, csr.address, exp_rd, readdata);
            count_error();
         end
         if (csr.write && waitrequest) begin
            case (csr.address)
               ADDR_NUMPKTS:       m_num = csr.writedata;
               ADDR_RANDOMPAYLOAD: m_rnd = csr.writedata[0];
               ADDR_STOP:          m_stop = csr.writedata[0];
               ADDR_MACSA0:        m_sa0 = csr.writedata;
               ADDR_MACSA1:        m_sa1 = csr.writedata[15:0];
               ADDR_MACDA0:        m_da0 = csr.writedata;
               ADDR_MACDA1:        m_da1 = csr.writedata[15:0];
               ADDR_RNDSEED0:      m_seed0 = csr.writedata;
               ADDR_RNDSEED1:      m_seed1 = csr.writedata;
               ADDR_RNDSEED2:      m_seed2 = csr.writedata[4:0];
               ADDR_PKTLENGTH: begin
                  m_len = (csr.writedata > 9000) ? 14'd9000 : csr.writedata[13:0];
               end
               ADDR_START: if (csr.writedata[0]) begin   // New run
                  m_count = '0;
                  m_seq = '0;
                  lanes = {m_seed2, m_seed1, m_seed0};
               end
               default: ;
            endcase
         end
         stop_age = m_stop ? stop_age + 1 : 0;

         if (test_done) begin
            if (beat_idx != 0) begin
               $display("Error in %0s: the last frame never finished", test_name);
               count_error();
            end
            if (t_frames > 0 && !m_stop && m_count != m_num) begin
               $display("Error in %0s: run sent %0d frames, not %0d",
                        test_name, m_count, m_num);
               count_error();
            end
            if (m_stop && m_count >= m_num) begin
               $display("Error in %0s: stop did not end the run early", test_name);
               count_error();
            end
            $display("%0s %0s: %0d frames, %0d beats, %0d errors",
                     (t_errs == 0) ? "PASS" : "FAIL", test_name, t_frames, t_beats, t_errs);
            n_tests++;
            if (t_errs != 0) n_failed++;
            {t_errs, t_beats, t_frames} = '0;
         end
         if (all_done) begin
            $display("Tests: %0d run, %0d failed, %0d errors", n_tests, n_failed, errors);
         end
      end
   end

   initial begin
      errors = 0;
      {t_errs, t_beats, t_frames, n_tests, n_failed, f_len} = '0;
   end

endmodule

/* tests/pktgen_props.sv */
// --------------------------------------
// Stream properties
// --------------------------------------

module pktgen_props import pktgen_pkg::*; (
   input logic     clk,
   input logic     reset,
   input logic     tx_ready,
   input st_beat_t tx
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_count = 0;   // Failed property count

   // Stalled beat must not change
   a_hold: assert property (@(posedge clk) disable iff (reset)
      tx.valid && !tx_ready |=> $stable(tx))
      else begin
         fail_count++;
         $error("Beat changed while ready was low");
      end

   a_flags: assert property (@(posedge clk) disable iff (reset)
      (tx.sop || tx.eop) |-> tx.valid)
      else begin
         fail_count++;
         $error("sop or eop without valid");
      end

   a_empty: assert property (@(posedge clk) disable iff (reset)
      !tx.eop |-> tx.empty == 3'd0)                  // Only the last beat is partial
      else begin
         fail_count++;
         $error("empty set on a beat without eop");
      end

endmodule

bind frame_sequencer pktgen_props u_props (
   .clk      (clk),
   .reset    (reset),
   .tx_ready (tx_ready),
   .tx       (tx)
);

/* tests/pktgen_tb.sv */
// --------------------------------------
// Frame generator testbench
// --------------------------------------

module pktgen_tb import pktgen_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   // Cycle budget of frames x (L/8 + 4) x 4 per test plus bus traffic
   localparam int RUN_CYCLES = 3 * (24 / 8 + 4) * 4       // Incremental
                             + 4 * (200 / 8 + 4) * 4      // PRBS, longest length
                             + (4 + 5 + 9000 / 8 + 4) * 4 // Edge lengths
                             + 8 * (64 / 8 + 4) * 4;      // Stop and restart
   localparam int MARGIN     = 4000;

   logic              clk = 1'b0;
   logic              reset;
   csr_req_t          csr;
   logic [CSR_DW-1:0] readdata;
   logic              waitrequest;
   logic              tx_ready = 1'b1;
   st_beat_t          tx;
   logic              rand_ready;        // Random back-pressure on
   logic [8*24-1:0]   test_name;
   logic              test_done;
   logic              all_done;
   int                errors;
   logic [31:0]       rd;

   always #2 clk = ~clk;                 // 4 ns period

   pktgen_top uut (
      .clk         (clk),
      .reset       (reset),
      .csr         (csr),
      .readdata    (readdata),
      .waitrequest (waitrequest),
      .tx_ready    (tx_ready),
      .tx          (tx)
   );

   pktgen_checker u_checker (
      .clk         (clk),
      .reset       (reset),
      .csr         (csr),
      .readdata    (readdata),
      .waitrequest (waitrequest),
      .tx_ready    (tx_ready),
      .tx          (tx),
      .test_name   (test_name),
      .test_done   (test_done),
      .all_done    (all_done),
      .errors      (errors)
   );

   always @(negedge clk) begin
      tx_ready <= rand_ready ? (($urandom % 100) < 60) : 1'b1;  // About 60 % duty
   end

   // --------------------------------------
   // Bus tasks
   // --------------------------------------
   task automatic bus_access(input logic [7:0] addr, input logic wr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      @(negedge clk);
      csr = '{address: addr, read: ~wr, write: wr, writedata: wdata};
      do @(negedge clk); while (waitrequest);         // Held until waitrequest drops
      rdata = readdata;
      @(negedge clk);
      csr = '0;
   endtask

   task automatic reg_write(input logic [7:0] addr, input logic [31:0] wdata);
      logic [31:0] dummy;
      bus_access(addr, 1'b1, wdata, dummy);
   endtask

   task automatic reg_read(input logic [7:0] addr, output logic [31:0] rdata);
      bus_access(addr, 1'b0, '0, rdata);
   endtask

   task automatic finish_test(input logic [8*24-1:0] name);
      test_name = name;
      @(negedge clk) test_done = 1'b1;
      @(negedge clk) test_done = 1'b0;
   endtask

   // Start a run and wait for its last frame to leave the stream
   task automatic run_frames(input int n);
      reg_write(ADDR_NUMPKTS, n);
      reg_write(ADDR_START, 32'd1);
      do reg_read(ADDR_TXPKTCNT, rd); while (rd != n);
      while (tx.valid) @(negedge clk);
   endtask

   task automatic wait_quiet();
      int quiet;
      quiet = 0;
      while (quiet < 3) begin                          // Three idle cycles in a row
         @(negedge clk);
         quiet = tx.valid ? 0 : quiet + 1;
      end
   endtask

   // --------------------------------------
   // Test sequence
   // --------------------------------------
   initial begin
      void'($urandom(86418));
      reset = 1'b1;
      csr = '0;
      rand_ready = 1'b0;
      test_name = '0;
      test_done = 1'b0;
      all_done = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk) reset = 1'b0;

      // Reset seeds then masking and clamping
      reg_read(ADDR_RNDSEED0, rd);
      reg_read(ADDR_RNDSEED1, rd);
      reg_read(ADDR_RNDSEED2, rd);
      reg_write(ADDR_MACSA0, 32'h1122_3344);
      reg_write(ADDR_MACSA1, 32'hFFFF_5566);
      reg_write(ADDR_MACDA0, 32'hA1A2_A3A4);
      reg_write(ADDR_MACDA1, 32'h1234_B5B6);
      reg_write(ADDR_RNDSEED2, 32'hFFFF_FFFF);
      reg_write(ADDR_PKTLENGTH, 32'd20000);
      reg_write(ADDR_NUMPKTS, 32'd7);
      for (int a = 0; a <= 13; a++) begin
         reg_read(8'(a), rd);                          // Includes START and address 1
      end
      finish_test("registers");

      reg_write(ADDR_RANDOMPAYLOAD, 32'd0);
      reg_write(ADDR_PKTLENGTH, 32'd21);
      run_frames(3);
      reg_read(ADDR_TXPKTCNT, rd);
      finish_test("incremental");

      rand_ready = 1'b1;
      reg_write(ADDR_RANDOMPAYLOAD, 32'd1);
      reg_write(ADDR_RNDSEED0, $urandom);
      reg_write(ADDR_RNDSEED1, $urandom);
      reg_write(ADDR_RNDSEED2, $urandom);
      reg_write(ADDR_PKTLENGTH, $urandom_range(200, 1));
      run_frames(4);
      finish_test("prbs_backpressure");

      rand_ready = 1'b0;
      reg_write(ADDR_RANDOMPAYLOAD, 32'd0);
      reg_write(ADDR_PKTLENGTH, 32'd0);
      run_frames(1);
      reg_write(ADDR_PKTLENGTH, 32'd8);
      run_frames(1);
      reg_write(ADDR_PKTLENGTH, 32'd20000);          // Clamped to 9000
      run_frames(1);
      finish_test("edge_lengths");

      rand_ready = 1'b1;
      reg_write(ADDR_PKTLENGTH, 32'd64);
      reg_write(ADDR_NUMPKTS, 32'd40);
      reg_write(ADDR_START, 32'd1);
      do reg_read(ADDR_TXPKTCNT, rd); while (rd < 2);
      reg_write(ADDR_STOP, 32'd1);
      wait_quiet();
      reg_read(ADDR_TXPKTCNT, rd);
      finish_test("stop_mid_run");

      reg_write(ADDR_STOP, 32'd0);
      run_frames(2);
      finish_test("restart_after_stop");

      @(negedge clk) all_done = 1'b1;
      @(negedge clk) all_done = 1'b0;
      @(negedge clk);
      if (errors == 0 && uut.u_frame_sequencer.u_props.fail_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (RUN_CYCLES + MARGIN) @(posedge clk);
      $display("Timeout: the tests did not finish within the cycle budget");
      $display("Regression failed");
      $finish;
   end

endmodule
